// ==== src/cp0_consts.svh ====
// CP0 constants
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// Register addresses
`define CP0_INDEX       5'd0
`define CP0_RANDOM      5'd1
`define CP0_ENTRYLO0    5'd2
`define CP0_ENTRYLO1    5'd3
`define CP0_PAGEMASK    5'd5
`define CP0_WIRED       5'd6
`define CP0_BADVADDR    5'd8
`define CP0_COUNT       5'd9
`define CP0_ENTRYHI     5'd10
`define CP0_COMPARE     5'd11
`define CP0_STATUS      5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15
`define CP0_CONFIG      5'd16

// Exception types from the pipeline, zero means none
`define EXCT_INTR       4'd1
`define EXCT_CPU        4'd2
`define EXCT_RI         4'd3
`define EXCT_OV         4'd4
`define EXCT_TRAP       4'd5
`define EXCT_SYSC       4'd6
`define EXCT_BP         4'd7
`define EXCT_ADEL       4'd8
`define EXCT_ADES       4'd9
`define EXCT_TLBR       4'd10
`define EXCT_TLBI       4'd11
`define EXCT_TLBM       4'd12
`define EXCT_ERET       4'd13

// Architectural ExcCode values
`define EXCC_INTR       5'h00
`define EXCC_TLBL       5'h02
`define EXCC_TLBS       5'h03
`define EXCC_ADEL       5'h04
`define EXCC_ADES       5'h05
`define EXCC_SYSC       5'h08
`define EXCC_BP         5'h09
`define EXCC_RI         5'h0a
`define EXCC_CPU        5'h0b
`define EXCC_OV         5'h0c
`define EXCC_TR         5'h0d

`define TLB_ENTRIES     32
`define RANDOM_RST      5'd31

// Status bit positions
`define STATUS_EXL      1
`define STATUS_ERL      2
`define STATUS_UM       4
`define VPN2_LSB        13

`define STATUS_WMASK    32'h1040_ff17 // CU0 BEV IM UM ERL EXL IE
`define ENTRYLO_WMASK   32'h03ff_ffff
`define PAGEMASK_WMASK  32'h1fff_e000
`define ENTRYHI_WMASK   32'hffff_e0ff // VPN2 and ASID
`define CAUSE_WMASK     32'h0080_0300 // IV and IP[1:0]

`define PRID_VALUE      32'h0001_8000
`define CONFIG_VALUE    32'h0000_0080 // Standard TLB, little endian
`define STATUS_RST      32'h0040_0004

`endif

// ==== src/cp0_pkg.sv ====
// CP0 shared types
`include "cp0_consts.svh"

package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  cp0Addr_t;
    typedef logic [3:0]  excType_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [$clog2(`TLB_ENTRIES)-1:0] tlbIdx_t;
    typedef logic [5:0]  hwInt_t;

    // Exception request from the pipeline
    typedef struct packed {
        logic       valid;
        excType_t   excType;
        word_t      pc;
        word_t      badVAddr;
        logic [1:0] cpNum;
        logic       isStore;
        logic       inSlot;
    } excReq_t;

    typedef struct packed {
        logic       setExl;
        logic       clrExl;
        logic       loadEpc;
        word_t      epcValue;
        logic       bd;
        logic       loadCode;
        excCode_t   excCode;
        logic       loadBadVAddr;
        word_t      badVAddr;
        logic       loadVpn2;
        logic       loadCe;
        logic [1:0] ce;
    } excUpdate_t;

    // One enable per writable register
    typedef struct packed {
        word_t data;
        logic  index;
        logic  entryLo0;
        logic  entryLo1;
        logic  pageMask;
        logic  wired;
        logic  badVAddr;
        logic  count;
        logic  entryHi;
        logic  compare;
        logic  status;
        logic  cause;
        logic  epc;
    } cp0Write_t;

endpackage

// ==== src/excControl.sv ====
// Exception and write control
`timescale 1ns/1ps
`include "cp0_consts.svh"

module excControl (
    input  cp0_pkg::excReq_t    excReq_i,
    input  logic                wrEn_i,
    input  cp0_pkg::cp0Addr_t   addr_i,
    input  cp0_pkg::word_t      wrData_i,
    input  logic                probeWr_i,
    input  cp0_pkg::word_t      probeIndex_i,
    input  logic                exl_i,
    output cp0_pkg::excUpdate_t update_o,
    output cp0_pkg::cp0Write_t  write_o
);
    import cp0_pkg::*;

    excCode_t excCode;
    logic     isFault;
    logic     isAddrErr;
    logic     isTlbErr;
    logic     swEn;

    always_comb begin
        excCode = `EXCC_INTR;
        isFault = 1'b1;
        case (excReq_i.excType)
            `EXCT_INTR: excCode = `EXCC_INTR;
            `EXCT_CPU:  excCode = `EXCC_CPU;
            `EXCT_RI:   excCode = `EXCC_RI;
            `EXCT_OV:   excCode = `EXCC_OV;
            `EXCT_TRAP: excCode = `EXCC_TR;
            `EXCT_SYSC: excCode = `EXCC_SYSC;
            `EXCT_BP:   excCode = `EXCC_BP;
            `EXCT_ADEL: excCode = `EXCC_ADEL;
            `EXCT_ADES: excCode = `EXCC_ADES;
            `EXCT_TLBR,
            `EXCT_TLBI: excCode = excReq_i.isStore ? `EXCC_TLBS : `EXCC_TLBL;
            `EXCT_TLBM: excCode = `EXCC_TLBS;
            default:    isFault = 1'b0; // ERET or no exception
        endcase
    end

    assign isAddrErr = (excReq_i.excType == `EXCT_ADEL) || (excReq_i.excType == `EXCT_ADES);
    assign isTlbErr  = (excReq_i.excType == `EXCT_TLBR) || (excReq_i.excType == `EXCT_TLBI)
                    || (excReq_i.excType == `EXCT_TLBM);

    always_comb begin
        update_o              = '0;
        update_o.setExl       = excReq_i.valid & isFault;
        update_o.clrExl       = excReq_i.valid & (excReq_i.excType == `EXCT_ERET);
        // Nested exceptions keep the first EPC
        update_o.loadEpc      = excReq_i.valid & isFault & ~exl_i;
        update_o.epcValue     = excReq_i.inSlot ? excReq_i.pc - 32'd4 : excReq_i.pc;
        update_o.bd           = excReq_i.inSlot;
        update_o.loadCode     = excReq_i.valid & isFault;
        update_o.excCode      = excCode;
        update_o.loadBadVAddr = excReq_i.valid & (isAddrErr | isTlbErr);
        update_o.badVAddr     = excReq_i.badVAddr;
        update_o.loadVpn2     = excReq_i.valid & isTlbErr;
        update_o.loadCe       = excReq_i.valid & (excReq_i.excType == `EXCT_CPU);
        update_o.ce           = excReq_i.cpNum;
    end

    // Exception beats probe, probe beats software
    assign swEn = wrEn_i & ~excReq_i.valid & ~probeWr_i;

    always_comb begin
        write_o       = '0;
        write_o.data  = probeWr_i ? probeIndex_i : wrData_i;
        write_o.index = probeWr_i & ~excReq_i.valid; // Carries P in bit 31
        if (swEn) begin
            case (addr_i)
                `CP0_INDEX:    write_o.index    = 1'b1;
                `CP0_ENTRYLO0: write_o.entryLo0 = 1'b1;
                `CP0_ENTRYLO1: write_o.entryLo1 = 1'b1;
                `CP0_PAGEMASK: write_o.pageMask = 1'b1;
                `CP0_WIRED:    write_o.wired    = 1'b1;
                `CP0_BADVADDR: write_o.badVAddr = 1'b1;
                `CP0_COUNT:    write_o.count    = 1'b1;
                `CP0_ENTRYHI:  write_o.entryHi  = 1'b1;
                `CP0_COMPARE:  write_o.compare  = 1'b1;
                `CP0_STATUS:   write_o.status   = 1'b1;
                `CP0_CAUSE:    write_o.cause    = 1'b1;
                `CP0_EPC:      write_o.epc      = 1'b1;
                default:       ;
            endcase
        end
    end

endmodule

// ==== src/cp0Regs.sv ====
// CP0 register file
`timescale 1ns/1ps
`include "cp0_consts.svh"

module cp0Regs (
    input  logic                clk,
    input  logic                rst,
    input  cp0_pkg::excUpdate_t update_i,
    input  cp0_pkg::cp0Write_t  write_i,
    input  cp0_pkg::cp0Addr_t   addr_i,
    input  cp0_pkg::hwInt_t     hwInt_i,
    input  cp0_pkg::word_t      count_i,
    input  cp0_pkg::word_t      compare_i,
    input  cp0_pkg::tlbIdx_t    random_i,
    input  cp0_pkg::tlbIdx_t    wired_i,
    output cp0_pkg::word_t      rdData_o,
    output logic                exl_o,
    output cp0_pkg::word_t      status_o,
    output cp0_pkg::word_t      cause_o,
    output cp0_pkg::word_t      epc_o,
    output cp0_pkg::word_t      entryHi_o,
    output logic                userMode_o
);
    import cp0_pkg::*;

    word_t   status;
    word_t   cause;
    word_t   epc;
    word_t   badVAddr;
    word_t   entryLo0;
    word_t   entryLo1;
    word_t   pageMask;
    word_t   entryHi;
    logic    indexP;
    tlbIdx_t indexVal;
    word_t   indexWord;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status <= `STATUS_RST;
        end else begin
            if (write_i.status) begin
                status <= (status & ~`STATUS_WMASK) | (write_i.data & `STATUS_WMASK);
            end
            if (update_i.setExl) begin
                status[`STATUS_EXL] <= 1'b1;
            end else if (update_i.clrExl) begin
                status[`STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cause <= '0;
        end else begin
            if (write_i.cause) begin
                cause <= (cause & ~`CAUSE_WMASK) | (write_i.data & `CAUSE_WMASK);
            end
            if (update_i.loadEpc) begin
                cause[31] <= update_i.bd; // BD
            end
            if (update_i.loadCe) begin
                cause[29:28] <= update_i.ce;
            end
            if (update_i.loadCode) begin
                cause[6:2] <= update_i.excCode;
            end
            cause[15:10] <= hwInt_i; // Pins sampled every cycle
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.loadEpc) begin
            epc <= update_i.epcValue;
        end else if (write_i.epc) begin
            epc <= write_i.data;
        end

        if (update_i.loadBadVAddr) begin
            badVAddr <= update_i.badVAddr;
        end else if (write_i.badVAddr) begin
            badVAddr <= write_i.data;
        end

        if (update_i.loadVpn2) begin
            entryHi[31:`VPN2_LSB] <= update_i.badVAddr[31:`VPN2_LSB];
        end else if (write_i.entryHi) begin
            entryHi <= write_i.data & `ENTRYHI_WMASK;
        end

        if (write_i.entryLo0) begin
            entryLo0 <= write_i.data & `ENTRYLO_WMASK;
        end
        if (write_i.entryLo1) begin
            entryLo1 <= write_i.data & `ENTRYLO_WMASK;
        end
        if (write_i.pageMask) begin
            pageMask <= write_i.data & `PAGEMASK_WMASK;
        end
        if (write_i.index) begin
            indexP   <= write_i.data[31];
            indexVal <= write_i.data[$bits(tlbIdx_t)-1:0];
        end
    end

    always_comb begin
        indexWord                       = '0;
        indexWord[31]                   = indexP;
        indexWord[$bits(tlbIdx_t)-1:0]  = indexVal;
    end

    always_comb begin
        case (addr_i)
            `CP0_INDEX:    rdData_o = indexWord;
            `CP0_RANDOM:   rdData_o = word_t'(random_i);
            `CP0_ENTRYLO0: rdData_o = entryLo0;
            `CP0_ENTRYLO1: rdData_o = entryLo1;
            `CP0_PAGEMASK: rdData_o = pageMask;
            `CP0_WIRED:    rdData_o = word_t'(wired_i);
            `CP0_BADVADDR: rdData_o = badVAddr;
            `CP0_COUNT:    rdData_o = count_i;
            `CP0_ENTRYHI:  rdData_o = entryHi;
            `CP0_COMPARE:  rdData_o = compare_i;
            `CP0_STATUS:   rdData_o = status;
            `CP0_CAUSE:    rdData_o = cause;
            `CP0_EPC:      rdData_o = epc;
            `CP0_PRID:     rdData_o = `PRID_VALUE;
            `CP0_CONFIG:   rdData_o = `CONFIG_VALUE;
            default:       rdData_o = '0;
        endcase
    end

    assign exl_o      = status[`STATUS_EXL];
    assign status_o   = status;
    assign cause_o    = cause;
    assign epc_o      = epc;
    assign entryHi_o  = entryHi;
    // Kernel whenever EXL or ERL is set
    assign userMode_o = status[`STATUS_UM] & ~status[`STATUS_EXL] & ~status[`STATUS_ERL];

endmodule

// ==== src/cp0Timer.sv ====
// Count and Compare timer
`timescale 1ns/1ps

module cp0Timer (
    input  logic               clk,
    input  logic               rst,
    input  cp0_pkg::cp0Write_t write_i,
    output cp0_pkg::word_t     count_o,
    output cp0_pkg::word_t     compare_o,
    output logic               timerInt_o
);
    import cp0_pkg::*;

    word_t count;
    word_t compare;
    logic  timerInt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count    <= '0;
            compare  <= '0;
            timerInt <= 1'b0;
        end else begin
            count <= write_i.count ? write_i.data : count + 32'd1;
            if (write_i.compare) begin
                compare  <= write_i.data;
                timerInt <= 1'b0; // Acknowledge
            end else if ((compare != '0) && (count == compare)) begin
                timerInt <= 1'b1;
            end
        end
    end

    assign count_o    = count;
    assign compare_o  = compare;
    assign timerInt_o = timerInt;

endmodule

// ==== src/tlbRandom.sv ====
// Wired and Random registers
`timescale 1ns/1ps
`include "cp0_consts.svh"

module tlbRandom (
    input  logic               clk,
    input  logic               rst,
    input  cp0_pkg::cp0Write_t write_i,
    output cp0_pkg::tlbIdx_t   random_o,
    output cp0_pkg::tlbIdx_t   wired_o
);
    import cp0_pkg::*;

    tlbIdx_t wired;
    tlbIdx_t random;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wired  <= '0;
            random <= `RANDOM_RST;
        end else if (write_i.wired) begin
            wired  <= write_i.data[$bits(tlbIdx_t)-1:0];
            random <= `RANDOM_RST; // Restart above the new floor
        end else begin
            random <= (random == wired) ? `RANDOM_RST : random - 1'b1;
        end
    end

    assign random_o = random;
    assign wired_o  = wired;

endmodule

// ==== src/cp0Top.sv ====
// CP0 top level
`timescale 1ns/1ps

module cp0Top (
    input  logic              clk,
    input  logic              rst,
    input  cp0_pkg::excReq_t  excReq_i,
    input  logic              wrEn_i,
    input  cp0_pkg::cp0Addr_t addr_i,
    input  cp0_pkg::word_t    wrData_i,
    input  logic              probeWr_i,
    input  cp0_pkg::word_t    probeIndex_i,
    input  cp0_pkg::hwInt_t   hwInt_i,
    output cp0_pkg::word_t    rdData_o,
    output cp0_pkg::word_t    status_o,
    output cp0_pkg::word_t    cause_o,
    output cp0_pkg::word_t    epc_o,
    output cp0_pkg::word_t    entryHi_o,
    output cp0_pkg::tlbIdx_t  random_o,
    output logic              userMode_o,
    output logic              timerInt_o
);
    import cp0_pkg::*;

    excUpdate_t update;
    cp0Write_t  write;
    logic       exl;
    word_t      count;
    word_t      compare;
    tlbIdx_t    random;
    tlbIdx_t    wired;

    excControl u_excControl (
        .excReq_i     (excReq_i),
        .wrEn_i       (wrEn_i),
        .addr_i       (addr_i),
        .wrData_i     (wrData_i),
        .probeWr_i    (probeWr_i),
        .probeIndex_i (probeIndex_i),
        .exl_i        (exl),
        .update_o     (update),
        .write_o      (write)
    );

    cp0Regs u_cp0Regs (
        .clk        (clk),
        .rst        (rst),
        .update_i   (update),
        .write_i    (write),
        .addr_i     (addr_i),
        .hwInt_i    (hwInt_i),
        .count_i    (count),
        .compare_i  (compare),
        .random_i   (random),
        .wired_i    (wired),
        .rdData_o   (rdData_o),
        .exl_o      (exl),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .epc_o      (epc_o),
        .entryHi_o  (entryHi_o),
        .userMode_o (userMode_o)
    );

    cp0Timer u_cp0Timer (
        .clk        (clk),
        .rst        (rst),
        .write_i    (write),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    tlbRandom u_tlbRandom (
        .clk      (clk),
        .rst      (rst),
        .write_i  (write),
        .random_o (random),
        .wired_o  (wired)
    );

    assign random_o = random;

endmodule

// ==== bench/cp0_properties.sv ====
// CP0 bound assertions
`timescale 1ns/1ps
`include "cp0_consts.svh"

module cp0Props (
    input logic               clk,
    input logic               rst,
    input cp0_pkg::excReq_t   excReq_i,
    input logic               exl_i,
    input cp0_pkg::word_t     epc_i,
    input cp0_pkg::cp0Write_t write_i,
    input logic               timerInt_i,
    input cp0_pkg::tlbIdx_t   random_i,
    input cp0_pkg::tlbIdx_t   wired_i
);
    import cp0_pkg::*;

    logic isFault;

    assign isFault = excReq_i.valid && (excReq_i.excType >= `EXCT_INTR)
                  && (excReq_i.excType <= `EXCT_TLBM);

    // First exception records the restart PC
    excLoadsEpc: assert property (@(posedge clk) disable iff (rst)
        isFault && !exl_i |=> epc_i == $past(excReq_i.inSlot ? excReq_i.pc - 32'd4 : excReq_i.pc))
        else $error("EPC not loaded on exception entry");

    compareClearsTimer: assert property (@(posedge clk) disable iff (rst)
        write_i.compare |=> !timerInt_i)
        else $error("Timer interrupt still high after a Compare write");

    randomAboveWired: assert property (@(posedge clk) disable iff (rst)
        random_i >= wired_i)
        else $error("Random below Wired");

endmodule

bind cp0Top cp0Props u_props (
    .clk        (clk),
    .rst        (rst),
    .excReq_i   (excReq_i),
    .exl_i      (exl),
    .epc_i      (epc_o),
    .write_i    (write),
    .timerInt_i (timerInt_o),
    .random_i   (random),
    .wired_i    (wired)
);

// ==== bench/cp0Tb.sv ====
// CP0 testbench
`timescale 1ns/1ps
`include "cp0_consts.svh"

module cp0Tb;
    import cp0_pkg::*;

    localparam int REG_ROUNDS   = 3;
    localparam int EXC_ROUNDS   = 20;
    localparam int FAULT_ROUNDS = 20;
    localparam int TIMER_ROUNDS = 5;
    localparam int TIMER_MAX    = 22;
    localparam int RAND_ROUNDS  = 4;
    localparam int RAND_SAMPLES = 80;
    localparam int PRIO_ROUNDS  = 4;
    // Upper bound on clock cycles per test, summed
    localparam int TEST_CYCLES  = 10 + REG_ROUNDS * 18 * 4 + 4 + EXC_ROUNDS * 8
                                + FAULT_ROUNDS * 4 + TIMER_ROUNDS * (TIMER_MAX + 16)
                                + RAND_ROUNDS * (RAND_SAMPLES + 4) + PRIO_ROUNDS * 12;
    localparam int MARGIN       = 200;

    localparam excType_t FAULT_TYPES [6] = '{`EXCT_ADEL, `EXCT_ADES, `EXCT_TLBR,
                                             `EXCT_TLBI, `EXCT_TLBM, `EXCT_CPU};

    logic      clk;
    logic      rst;
    excReq_t   excReq;
    logic      wrEn;
    cp0Addr_t  addr;
    word_t     wrData;
    logic      probeWr;
    word_t     probeIndex;
    hwInt_t    hwInt;
    word_t     rdData;
    word_t     status;
    word_t     cause;
    word_t     epc;
    word_t     entryHi;
    tlbIdx_t   random;
    logic      userMode;
    logic      timerInt;

    // Shadow register model
    word_t     mStatus;
    word_t     mCause;
    word_t     mEpc;
    word_t     mBadVAddr;
    word_t     mIndex;
    word_t     mEntryLo0;
    word_t     mEntryLo1;
    word_t     mPageMask;
    word_t     mEntryHi;
    word_t     mCount;
    word_t     mCompare;
    tlbIdx_t   mWired;
    tlbIdx_t   mRandom;

    string     testName;
    int        errors;
    int        checks;
    int        testsRun;
    int        testsFailed;
    int        errStart;

    cp0Top u_dut (
        .clk          (clk),
        .rst          (rst),
        .excReq_i     (excReq),
        .wrEn_i       (wrEn),
        .addr_i       (addr),
        .wrData_i     (wrData),
        .probeWr_i    (probeWr),
        .probeIndex_i (probeIndex),
        .hwInt_i      (hwInt),
        .rdData_o     (rdData),
        .status_o     (status),
        .cause_o      (cause),
        .epc_o        (epc),
        .entryHi_o    (entryHi),
        .random_o     (random),
        .userMode_o   (userMode),
        .timerInt_o   (timerInt)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic excCode_t excCodeFor(input excType_t t, input logic isStore);
        case (t)
            `EXCT_CPU:  return `EXCC_CPU;
            `EXCT_RI:   return `EXCC_RI;
            `EXCT_OV:   return `EXCC_OV;
            `EXCT_TRAP: return `EXCC_TR;
            `EXCT_SYSC: return `EXCC_SYSC;
            `EXCT_BP:   return `EXCC_BP;
            `EXCT_ADEL: return `EXCC_ADEL;
            `EXCT_ADES: return `EXCC_ADES;
            `EXCT_TLBR,
            `EXCT_TLBI: return isStore ? `EXCC_TLBS : `EXCC_TLBL;
            `EXCT_TLBM: return `EXCC_TLBS;
            default:    return `EXCC_INTR;
        endcase
    endfunction

    function automatic word_t modelRead(input cp0Addr_t a);
        case (a)
            `CP0_INDEX:    return mIndex;
            `CP0_RANDOM:   return 32'(mRandom);
            `CP0_ENTRYLO0: return mEntryLo0;
            `CP0_ENTRYLO1: return mEntryLo1;
            `CP0_PAGEMASK: return mPageMask;
            `CP0_WIRED:    return 32'(mWired);
            `CP0_BADVADDR: return mBadVAddr;
            `CP0_COUNT:    return mCount;
            `CP0_ENTRYHI:  return mEntryHi;
            `CP0_COMPARE:  return mCompare;
            `CP0_STATUS:   return mStatus;
            `CP0_CAUSE:    return mCause;
            `CP0_EPC:      return mEpc;
            `CP0_PRID:     return `PRID_VALUE;
            `CP0_CONFIG:   return `CONFIG_VALUE;
            default:       return '0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mStatus  <= `STATUS_RST;
            mCause   <= '0;
            mCount   <= '0;
            mCompare <= '0;
            mWired   <= '0;
            mRandom  <= `RANDOM_RST;
        end else begin
            mCount  <= mCount + 32'd1;
            mRandom <= (mRandom == mWired) ? `RANDOM_RST : mRandom - 5'd1;
            if (excReq.valid) begin
                if ((excReq.excType >= `EXCT_INTR) && (excReq.excType <= `EXCT_TLBM)) begin
                    mStatus[`STATUS_EXL] <= 1'b1;
                    mCause[6:2] <= excCodeFor(excReq.excType, excReq.isStore);
                    if (!mStatus[`STATUS_EXL]) begin
                        mEpc       <= excReq.inSlot ? excReq.pc - 32'd4 : excReq.pc;
                        mCause[31] <= excReq.inSlot;
                    end
                    if (excReq.excType >= `EXCT_ADEL) begin // Address and TLB faults
                        mBadVAddr <= excReq.badVAddr;
                    end
                    if (excReq.excType >= `EXCT_TLBR) begin
                        mEntryHi[31:13] <= excReq.badVAddr[31:13];
                    end
                    if (excReq.excType == `EXCT_CPU) begin
                        mCause[29:28] <= excReq.cpNum;
                    end
                end else if (excReq.excType == `EXCT_ERET) begin
                    mStatus[`STATUS_EXL] <= 1'b0;
                end
            end else if (probeWr) begin
                mIndex <= {probeIndex[31], 26'd0, probeIndex[4:0]};
            end else if (wrEn) begin
                case (addr)
                    `CP0_INDEX:    mIndex    <= {wrData[31], 26'd0, wrData[4:0]};
                    `CP0_ENTRYLO0: mEntryLo0 <= wrData & `ENTRYLO_WMASK;
                    `CP0_ENTRYLO1: mEntryLo1 <= wrData & `ENTRYLO_WMASK;
                    `CP0_PAGEMASK: mPageMask <= wrData & `PAGEMASK_WMASK;
                    `CP0_BADVADDR: mBadVAddr <= wrData;
                    `CP0_COUNT:    mCount    <= wrData;
                    `CP0_ENTRYHI:  mEntryHi  <= wrData & `ENTRYHI_WMASK;
                    `CP0_EPC:      mEpc      <= wrData;
                    `CP0_COMPARE:  mCompare  <= wrData;
                    `CP0_STATUS:
                        mStatus <= (mStatus & ~`STATUS_WMASK) | (wrData & `STATUS_WMASK);
                    `CP0_CAUSE:    mCause    <= (mCause & ~`CAUSE_WMASK) | (wrData & `CAUSE_WMASK);
                    `CP0_WIRED: begin
                        mWired  <= wrData[4:0];
                        mRandom <= `RANDOM_RST;
                    end
                    default: ;
                endcase
            end
            mCause[15:10] <= hwInt; // After the Cause write so the pins win
        end
    end

    task automatic check(input string what, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        errStart = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors != errStart) begin
            testsFailed++;
            $display("Test %s: FAILED, %0d errors", testName, errors - errStart);
        end else begin
            $display("Test %s: ok", testName);
        end
    endtask

    task automatic writeReg(input cp0Addr_t a, input word_t d);
        @(posedge clk);
        wrEn   <= 1'b1;
        addr   <= a;
        wrData <= d;
        @(posedge clk);
        wrEn   <= 1'b0;
        @(negedge clk);
    endtask

    task automatic readReg(input cp0Addr_t a, output word_t d);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        d = rdData;
    endtask

    task automatic raiseExc(input excType_t t, input word_t pc, input word_t bva,
                            input logic [1:0] cp, input logic st, input logic slot);
        excReq_t req;
        req          = '0;
        req.valid    = 1'b1;
        req.excType  = t;
        req.pc       = pc;
        req.badVAddr = bva;
        req.cpNum    = cp;
        req.isStore  = st;
        req.inSlot   = slot;
        @(posedge clk);
        excReq <= req;
        @(posedge clk);
        excReq <= '0;
        @(negedge clk);
    endtask

    task automatic regTest();
        word_t rd;
        startTest("regReadback");
        check("reset Status", `STATUS_RST, status);
        check("reset Cause", 32'd0, cause);
        check("reset timer", 32'd0, 32'(timerInt));
        check("reset userMode", 32'd0, 32'(userMode));
        for (int r = 0; r < REG_ROUNDS; r++) begin
            for (int a = 0; a < 18; a++) begin
                writeReg(5'(a), $urandom);
                readReg(5'(a), rd);
                check($sformatf("addr %0d", a), modelRead(5'(a)), rd);
            end
        end
        endTest();
    endtask

    task automatic excTest();
        excType_t t;
        word_t    pc;
        word_t    expEpc;
        logic     slot;
        logic     st;
        startTest("excEntry");
        writeReg(`CP0_STATUS, 32'h0000_0010); // User mode, EXL and ERL clear
        check("userMode before", 32'd1, 32'(userMode));
        for (int r = 0; r < EXC_ROUNDS; r++) begin
            t    = 4'(1 + $urandom % 12);
            pc   = $urandom & ~32'd3;
            slot = 1'($urandom);
            st   = 1'($urandom);
            raiseExc(t, pc, $urandom, 2'($urandom), st, slot);
            expEpc = slot ? pc - 32'd4 : pc;
            check("EPC", expEpc, epc);
            check("BD", 32'(slot), 32'(cause[31]));
            check("ExcCode", 32'(excCodeFor(t, st)), 32'(cause[6:2]));
            check("EXL", 32'd1, 32'(status[`STATUS_EXL]));
            check("userMode", 32'd0, 32'(userMode));
            // Nested exception keeps the first EPC
            t = 4'(1 + $urandom % 12);
            raiseExc(t, pc + 32'h100, $urandom, 2'($urandom), st, 1'b0);
            check("nested EPC", expEpc, epc);
            check("nested ExcCode", 32'(excCodeFor(t, st)), 32'(cause[6:2]));
            raiseExc(`EXCT_ERET, '0, '0, 2'd0, 1'b0, 1'b0);
            check("EXL after ERET", 32'd0, 32'(status[`STATUS_EXL]));
            check("userMode after ERET", 32'd1, 32'(userMode));
        end
        endTest();
    endtask

    task automatic faultTest();
        excType_t   t;
        word_t      bva;
        word_t      oldHi;
        word_t      rd;
        logic       st;
        logic [1:0] cp;
        startTest("faults");
        for (int r = 0; r < FAULT_ROUNDS; r++) begin
            t     = FAULT_TYPES[$urandom % 6];
            bva   = $urandom;
            st    = 1'($urandom);
            cp    = 2'($urandom);
            oldHi = mEntryHi;
            raiseExc(t, $urandom & ~32'd3, bva, cp, st, 1'b0);
            check("ExcCode", 32'(excCodeFor(t, st)), 32'(cause[6:2]));
            if (t == `EXCT_CPU) begin
                check("CE", 32'(cp), 32'(cause[29:28]));
            end else begin
                if (t >= `EXCT_TLBR) begin
                    check("EntryHi", {bva[31:13], oldHi[12:0]}, entryHi);
                end
                readReg(`CP0_BADVADDR, rd);
                check("BadVAddr", bva, rd);
            end
        end
        endTest();
    endtask

    task automatic timerTest();
        word_t c;
        int    n;
        int    k;
        startTest("timer");
        for (int r = 0; r < TIMER_ROUNDS; r++) begin
            c = $urandom & 32'h7fff_ffff;
            n = 3 + int'($urandom % (TIMER_MAX - 2));
            writeReg(`CP0_COUNT, c);
            writeReg(`CP0_COMPARE, c + 32'(n));
            // Count is c+2 here, reaches Compare n-2 edges on, flag one edge later
            k = 0;
            while (!timerInt && k < n + 8) begin
                @(negedge clk);
                k++;
            end
            if (!timerInt) begin
                errors++;
                $display("Timer interrupt did not rise within %0d cycles", k);
            end else begin
                check("timer delay", 32'(n - 1), 32'(k));
            end
            writeReg(`CP0_COMPARE, c);
            check("timer after Compare write", 32'd0, 32'(timerInt));
        end
        endTest();
    endtask

    task automatic randomTest();
        tlbIdx_t w;
        tlbIdx_t expRand;
        word_t   rd;
        startTest("random");
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            w = 5'($urandom);
            writeReg(`CP0_WIRED, 32'(w));
            expRand = `RANDOM_RST;
            check("Random reload", 32'(expRand), 32'(random));
            readReg(`CP0_WIRED, rd);
            expRand = (expRand == w) ? `RANDOM_RST : expRand - 5'd1;
            check("Wired", 32'(w), rd);
            for (int s = 0; s < RAND_SAMPLES; s++) begin
                @(negedge clk);
                expRand = (expRand == w) ? `RANDOM_RST : expRand - 5'd1;
                check("Random", 32'(expRand), 32'(random));
            end
        end
        endTest();
    endtask

    task automatic priorityTest();
        excReq_t req;
        word_t   old;
        word_t   pw;
        word_t   rd;
        hwInt_t  h;
        startTest("priority");
        for (int r = 0; r < PRIO_ROUNDS; r++) begin
            req         = '0;
            req.valid   = 1'b1;
            req.excType = `EXCT_SYSC;
            req.pc      = $urandom & ~32'd3;
            old         = mEntryLo0;
            @(posedge clk);
            excReq <= req;
            wrEn   <= 1'b1;
            addr   <= `CP0_ENTRYLO0;
            wrData <= ~old;
            @(posedge clk);
            excReq <= '0;
            wrEn   <= 1'b0;
            readReg(`CP0_ENTRYLO0, rd);
            check("EntryLo0 beside exception", old, rd);

            old = mEntryLo1;
            pw  = $urandom;
            @(posedge clk);
            probeWr    <= 1'b1;
            probeIndex <= pw;
            wrEn       <= 1'b1;
            addr       <= `CP0_ENTRYLO1;
            wrData     <= ~old;
            @(posedge clk);
            probeWr <= 1'b0;
            wrEn    <= 1'b0;
            readReg(`CP0_ENTRYLO1, rd);
            check("EntryLo1 beside probe", old, rd);
            readReg(`CP0_INDEX, rd);
            check("probe Index", {pw[31], 26'd0, pw[4:0]}, rd);

            h = 6'($urandom | 1);
            @(posedge clk);
            hwInt <= h;
            @(negedge clk);
            check("IP same cycle", 32'd0, 32'(cause[15:10]));
            @(negedge clk);
            check("IP next cycle", 32'(h), 32'(cause[15:10]));
            @(posedge clk);
            hwInt <= '0;
            @(negedge clk);
        end
        endTest();
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN) * 40);
        $display("Watchdog: run still going after %0d cycles", TEST_CYCLES + MARGIN);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(28264));
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        testsFailed = 0;
        rst         = 1'b1;
        excReq      = '0;
        wrEn        = 1'b0;
        addr        = '0;
        wrData      = '0;
        probeWr     = 1'b0;
        probeIndex  = '0;
        hwInt       = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        regTest();
        excTest();
        faultTest();
        timerTest();
        randomTest();
        priorityTest();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/cp0_pkg.sv
src/excControl.sv
src/cp0Regs.sv
src/cp0Timer.sv
src/tlbRandom.sv
src/cp0Top.sv
bench/cp0_properties.sv
bench/cp0Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cp0Tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcp0Tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
